// File: hdl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int xlen      = 64;
    localparam int num_regs  = 32;
    localparam int reg_idx_w = 5;

    // major opcodes handled by this decoder
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_branch    = 7'b1100011;

    typedef enum logic [1:0] {
        fmt_r,
        fmt_i,
        fmt_b,
        fmt_other
    } t_ifmt;

    typedef enum logic [4:0] {
        uop_add,
        uop_sub,
        uop_sll,
        uop_slt,
        uop_sltu,
        uop_xor,
        uop_srl,
        uop_sra,
        uop_or,
        uop_and,
        uop_beq,
        uop_bne,
        uop_blt,
        uop_bge,
        uop_bltu,
        uop_bgeu,
        uop_illegal
    } t_uop;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } t_rv_r;

    typedef struct packed {
        logic [11:0]          imm_11_0;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } t_rv_i;

    // branch offset is scattered, bit 0 is implied zero
    typedef struct packed {
        logic                 imm_12;
        logic [5:0]           imm_10_5;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm_4_1;
        logic                 imm_11;
        logic [6:0]           opcode;
    } t_rv_b;

    typedef union packed {
        t_rv_r r;
        t_rv_i i;
        t_rv_b b;
    } t_rv_instr;

    function automatic t_ifmt get_ifmt(input logic [6:0] opcode);
        case (opcode)
            opc_op, opc_op_32:         return fmt_r;
            opc_op_imm, opc_op_imm_32: return fmt_i;
            opc_branch:                return fmt_b;
            default:                   return fmt_other;
        endcase
    endfunction

    // shared alu mapping for register and immediate forms
    function automatic t_uop alu_uop(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? uop_sub : uop_add;
            3'b001:  return uop_sll;
            3'b010:  return uop_slt;
            3'b011:  return uop_sltu;
            3'b100:  return uop_xor;
            3'b101:  return alt ? uop_sra : uop_srl;
            3'b110:  return uop_or;
            default: return uop_and;
        endcase
    endfunction

    function automatic t_uop rv_to_uop(input t_rv_instr instr);
        t_ifmt fmt;
        fmt = get_ifmt(instr.r.opcode);
        case (fmt)
            fmt_r: return alu_uop(instr.r.funct3, instr.r.funct7[5]);
            // no subi, so imm bit 10 only matters for the right shifts
            fmt_i: return alu_uop(instr.i.funct3,
                                  instr.i.imm_11_0[10] && (instr.i.funct3 == 3'b101));
            fmt_b: begin
                case (instr.b.funct3)
                    3'b000:  return uop_beq;
                    3'b001:  return uop_bne;
                    3'b100:  return uop_blt;
                    3'b101:  return uop_bge;
                    3'b110:  return uop_bltu;
                    3'b111:  return uop_bgeu;
                    default: return uop_illegal;
                endcase
            end
            default: return uop_illegal;
        endcase
    endfunction

    function automatic logic [xlen-1:0] sext_imm(input t_rv_instr instr);
        t_ifmt fmt;
        fmt = get_ifmt(instr.r.opcode);
        case (fmt)
            fmt_i:   return {{(xlen-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            fmt_b:   return {{(xlen-12){instr.b.imm_12}}, instr.b.imm_11,
                             instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/uinstr_if.sv
`timescale 1ns/1ps
`default_nettype none

// one decoded micro-instruction, DE1 to register read
interface uinstr_if;

    logic                                   valid;
    rv_decode_pkg::t_uop                    uop;
    logic                                   width_w;
    logic                                   dst_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]    dst;
    logic                                   src1_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]    src1;
    logic                                   src2_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]    src2;
    logic [rv_decode_pkg::xlen-1:0]         imm;
    logic [rv_decode_pkg::xlen-1:0]         pc;

    modport producer (
        output valid, uop, width_w, dst_valid, dst,
        output src1_valid, src1, src2_valid, src2, imm, pc
    );

    modport consumer (
        input valid, uop, width_w, dst_valid, dst,
        input src1_valid, src1, src2_valid, src2, imm, pc
    );

endinterface

`default_nettype wire

// File: hdl/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           instr_valid,
    input  rv_decode_pkg::t_rv_instr       instr,
    input  logic [rv_decode_pkg::xlen-1:0] pc,
    input  logic                           stall,
    input  logic                           flush,
    uinstr_if.producer                     uinstr
);

    // DE0 results
    rv_decode_pkg::t_ifmt                  de0_ifmt;
    rv_decode_pkg::t_uop                   de0_uop;
    logic                                  de0_width_w;
    logic                                  de0_dst_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]   de0_dst;
    logic                                  de0_src1_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]   de0_src1;
    logic                                  de0_src2_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]   de0_src2;
    logic [rv_decode_pkg::xlen-1:0]        de0_imm;

    // DE1 pipeline register
    logic                                  de1_valid;
    rv_decode_pkg::t_uop                   de1_uop;
    logic                                  de1_width_w;
    logic                                  de1_dst_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]   de1_dst;
    logic                                  de1_src1_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]   de1_src1;
    logic                                  de1_src2_valid;
    logic [rv_decode_pkg::reg_idx_w-1:0]   de1_src2;
    logic [rv_decode_pkg::xlen-1:0]        de1_imm;
    logic [rv_decode_pkg::xlen-1:0]        de1_pc;

    assign de0_ifmt = rv_decode_pkg::get_ifmt(instr.r.opcode);
    assign de0_uop  = rv_decode_pkg::rv_to_uop(instr);
    assign de0_imm  = rv_decode_pkg::sext_imm(instr);

    // operand fields come from the view picked by the format
    always_comb begin
        de0_width_w    = 1'b0;
        de0_dst_valid  = 1'b0;
        de0_dst        = '0;
        de0_src1_valid = 1'b0;
        de0_src1       = '0;
        de0_src2_valid = 1'b0;
        de0_src2       = '0;

        case (de0_ifmt)
            rv_decode_pkg::fmt_r: begin
                // opcode bit 3 marks the W forms
                de0_width_w    = instr.r.opcode[3];
                de0_dst_valid  = 1'b1;
                de0_dst        = instr.r.rd;
                de0_src1_valid = 1'b1;
                de0_src1       = instr.r.rs1;
                de0_src2_valid = 1'b1;
                de0_src2       = instr.r.rs2;
            end
            rv_decode_pkg::fmt_i: begin
                de0_width_w    = instr.i.opcode[3];
                de0_dst_valid  = 1'b1;
                de0_dst        = instr.i.rd;
                de0_src1_valid = 1'b1;
                de0_src1       = instr.i.rs1;
            end
            rv_decode_pkg::fmt_b: begin
                // compare only, no destination
                de0_src1_valid = 1'b1;
                de0_src1       = instr.b.rs1;
                de0_src2_valid = 1'b1;
                de0_src2       = instr.b.rs2;
            end
            default: begin
                // illegal or unsupported, no operands
            end
        endcase
    end

    // a flushed item held under stall must not come back
    always_ff @(posedge clk) begin
        if (reset) begin
            de1_valid <= 1'b0;
        end else if (!stall) begin
            de1_valid <= instr_valid;
        end else if (flush) begin
            de1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            de1_uop        <= de0_uop;
            de1_width_w    <= de0_width_w;
            de1_dst_valid  <= de0_dst_valid;
            de1_dst        <= de0_dst;
            de1_src1_valid <= de0_src1_valid;
            de1_src1       <= de0_src1;
            de1_src2_valid <= de0_src2_valid;
            de1_src2       <= de0_src2;
            de1_imm        <= de0_imm;
            de1_pc         <= pc;
        end
    end

    // mispredict kills the DE1 item this cycle
    assign uinstr.valid      = de1_valid & ~flush;
    assign uinstr.uop        = de1_uop;
    assign uinstr.width_w    = de1_width_w;
    assign uinstr.dst_valid  = de1_dst_valid;
    assign uinstr.dst        = de1_dst;
    assign uinstr.src1_valid = de1_src1_valid;
    assign uinstr.src1       = de1_src1;
    assign uinstr.src2_valid = de1_src2_valid;
    assign uinstr.src2       = de1_src2;
    assign uinstr.imm        = de1_imm;
    assign uinstr.pc         = de1_pc;

endmodule

`default_nettype wire

// File: hdl/reg_read.sv
`timescale 1ns/1ps
`default_nettype none

module reg_read (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                stall,
    input  logic                                flush,
    uinstr_if.consumer                          uinstr,
    input  logic                                wb_valid,
    input  logic [rv_decode_pkg::reg_idx_w-1:0] wb_reg,
    input  logic [rv_decode_pkg::xlen-1:0]      wb_data,
    output logic                                out_valid,
    output rv_decode_pkg::t_uop                 out_uop,
    output logic                                out_width_w,
    output logic                                out_dst_valid,
    output logic [rv_decode_pkg::reg_idx_w-1:0] out_dst,
    output logic [rv_decode_pkg::xlen-1:0]      out_src1_data,
    output logic [rv_decode_pkg::xlen-1:0]      out_src2_data,
    output logic [rv_decode_pkg::xlen-1:0]      out_imm,
    output logic [rv_decode_pkg::xlen-1:0]      out_pc
);

    logic [rv_decode_pkg::xlen-1:0] regs [rv_decode_pkg::num_regs];
    logic [rv_decode_pkg::xlen-1:0] rd0_src1_data;
    logic [rv_decode_pkg::xlen-1:0] rd0_src2_data;
    logic                           rd1_valid;

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv_decode_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_reg != '0)) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // unused source or x0 reads zero, same-cycle write is forwarded
    assign rd0_src1_data = (!uinstr.src1_valid || (uinstr.src1 == '0)) ? '0 :
                           (wb_valid && (wb_reg == uinstr.src1))       ? wb_data :
                                                                         regs[uinstr.src1];
    assign rd0_src2_data = (!uinstr.src2_valid || (uinstr.src2 == '0)) ? '0 :
                           (wb_valid && (wb_reg == uinstr.src2))       ? wb_data :
                                                                         regs[uinstr.src2];

    // incoming valid already has the DE1 flush applied
    always_ff @(posedge clk) begin
        if (reset) begin
            rd1_valid <= 1'b0;
        end else if (!stall) begin
            rd1_valid <= uinstr.valid;
        end else if (flush) begin
            rd1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_uop       <= uinstr.uop;
            out_width_w   <= uinstr.width_w;
            out_dst_valid <= uinstr.dst_valid;
            out_dst       <= uinstr.dst;
            out_src1_data <= rd0_src1_data;
            out_src2_data <= rd0_src2_data;
            out_imm       <= uinstr.imm;
            out_pc        <= uinstr.pc;
        end
    end

    assign out_valid = rd1_valid & ~flush;

endmodule

`default_nettype wire

// File: hdl/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_valid,
    input  logic [31:0]                         instr,
    input  logic [rv_decode_pkg::xlen-1:0]      pc,
    input  logic                                stall,
    input  logic                                flush,
    input  logic                                wb_valid,
    input  logic [rv_decode_pkg::reg_idx_w-1:0] wb_reg,
    input  logic [rv_decode_pkg::xlen-1:0]      wb_data,
    output logic                                out_valid,
    output rv_decode_pkg::t_uop                 out_uop,
    output logic                                out_width_w,
    output logic                                out_dst_valid,
    output logic [rv_decode_pkg::reg_idx_w-1:0] out_dst,
    output logic [rv_decode_pkg::xlen-1:0]      out_src1_data,
    output logic [rv_decode_pkg::xlen-1:0]      out_src2_data,
    output logic [rv_decode_pkg::xlen-1:0]      out_imm,
    output logic [rv_decode_pkg::xlen-1:0]      out_pc
);

    // DE1 item on its way to register read
    uinstr_if uinstr ();

    decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (rv_decode_pkg::t_rv_instr'(instr)),
        .pc          (pc),
        .stall       (stall),
        .flush       (flush),
        .uinstr      (uinstr.producer)
    );

    reg_read u_reg_read (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .flush         (flush),
        .uinstr        (uinstr.consumer),
        .wb_valid      (wb_valid),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data),
        .out_valid     (out_valid),
        .out_uop       (out_uop),
        .out_width_w   (out_width_w),
        .out_dst_valid (out_dst_valid),
        .out_dst       (out_dst),
        .out_src1_data (out_src1_data),
        .out_src2_data (out_src2_data),
        .out_imm       (out_imm),
        .out_pc        (out_pc)
    );

endmodule

`default_nettype wire

// File: sim/tb_ref_model.svh
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// expected RD1 contents for one item
typedef struct packed {
    rv_decode_pkg::t_uop            uop;
    logic                           width_w;
    logic                           dst_valid;
    logic [4:0]                     dst;
    logic [rv_decode_pkg::xlen-1:0] src1_data;
    logic [rv_decode_pkg::xlen-1:0] src2_data;
    logic [rv_decode_pkg::xlen-1:0] imm;
    logic [rv_decode_pkg::xlen-1:0] pc;
} t_expect;

// architectural state as seen before the current edge
logic [rv_decode_pkg::xlen-1:0] shadow_regs [32];

task automatic clear_shadow();
    for (int i = 0; i < 32; i++) begin
        shadow_regs[i] <= '0;
    end
endtask

// x0 stays zero
task automatic write_shadow(input logic [4:0] idx, input logic [63:0] data);
    if (idx != 5'd0) begin
        shadow_regs[idx] <= data;
    end
endtask

// write in the same cycle wins over the stored value
function automatic logic [63:0] read_operand(input logic [4:0] idx, input logic wr_en,
                                             input logic [4:0] wr_idx,
                                             input logic [63:0] wr_data);
    if (idx == 5'd0) begin
        return 64'd0;
    end
    if (wr_en && (wr_idx == idx)) begin
        return wr_data;
    end
    return shadow_regs[idx];
endfunction

function automatic rv_decode_pkg::t_uop alu_expected(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0: return alt ? rv_decode_pkg::uop_sub : rv_decode_pkg::uop_add;
        3'd1: return rv_decode_pkg::uop_sll;
        3'd2: return rv_decode_pkg::uop_slt;
        3'd3: return rv_decode_pkg::uop_sltu;
        3'd4: return rv_decode_pkg::uop_xor;
        3'd5: return alt ? rv_decode_pkg::uop_sra : rv_decode_pkg::uop_srl;
        3'd6: return rv_decode_pkg::uop_or;
        default: return rv_decode_pkg::uop_and;
    endcase
endfunction

function automatic t_expect expected_outputs(input logic [31:0] word, input logic [63:0] pc,
                                             input logic wr_en, input logic [4:0] wr_idx,
                                             input logic [63:0] wr_data);
    t_expect    e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       use_rs1;
    logic       use_rs2;
    opc = word[6:0];
    f3 = word[14:12];
    e = '0;
    e.uop = rv_decode_pkg::uop_illegal;
    e.pc = pc;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    if ((opc == rv_decode_pkg::opc_op) || (opc == rv_decode_pkg::opc_op_32)) begin
        e.uop = alu_expected(f3, word[30]);
        e.width_w = (opc == rv_decode_pkg::opc_op_32);
        e.dst_valid = 1'b1;
        e.dst = word[11:7];
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
    end else if ((opc == rv_decode_pkg::opc_op_imm) || (opc == rv_decode_pkg::opc_op_imm_32)) begin
        // only srai uses the alt bit
        e.uop = alu_expected(f3, word[30] && (f3 == 3'd5));
        e.width_w = (opc == rv_decode_pkg::opc_op_imm_32);
        e.dst_valid = 1'b1;
        e.dst = word[11:7];
        e.imm = {{52{word[31]}}, word[31:20]};
        use_rs1 = 1'b1;
    end else if (opc == rv_decode_pkg::opc_branch) begin
        case (f3)
            3'd0: e.uop = rv_decode_pkg::uop_beq;
            3'd1: e.uop = rv_decode_pkg::uop_bne;
            3'd4: e.uop = rv_decode_pkg::uop_blt;
            3'd5: e.uop = rv_decode_pkg::uop_bge;
            3'd6: e.uop = rv_decode_pkg::uop_bltu;
            3'd7: e.uop = rv_decode_pkg::uop_bgeu;
            default: e.uop = rv_decode_pkg::uop_illegal;
        endcase
        e.imm = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
    end
    e.src1_data = use_rs1 ? read_operand(word[19:15], wr_en, wr_idx, wr_data) : 64'd0;
    e.src2_data = use_rs2 ? read_operand(word[24:20], wr_en, wr_idx, wr_data) : 64'd0;
    return e;
endfunction

`endif

// File: sim/tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

    localparam int num_items      = 2000;
    localparam int timeout_cycles = 4 * num_items;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [63:0] pc;
    logic        stall;
    logic        flush;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [63:0] wb_data;

    logic                out_valid;
    rv_decode_pkg::t_uop out_uop;
    logic                out_width_w;
    logic                out_dst_valid;
    logic [4:0]          out_dst;
    logic [63:0]         out_src1_data;
    logic [63:0]         out_src2_data;
    logic [63:0]         out_imm;
    logic [63:0]         out_pc;

    integer      seed;
    int          error_count = 0;
    int          cycle_count = 0;
    logic [63:0] next_pc;

    `include "tb_ref_model.svh"

    // stage mirrors
    logic        model_de1_valid;
    logic [31:0] model_de1_word;
    logic [63:0] model_de1_pc;
    logic        model_rd1_valid;
    t_expect     model_rd1_exp;

    decode_top u_dut (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .stall(stall), .flush(flush), .wb_valid(wb_valid), .wb_reg(wb_reg),
        .wb_data(wb_data), .out_valid(out_valid), .out_uop(out_uop),
        .out_width_w(out_width_w), .out_dst_valid(out_dst_valid), .out_dst(out_dst),
        .out_src1_data(out_src1_data), .out_src2_data(out_src2_data),
        .out_imm(out_imm), .out_pc(out_pc)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // bias toward a few registers so bypass hits are common
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[8] ? {2'b00, r[2:0]} : r[4:0];
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        logic [31:0] r;
        w = $random(seed);
        r = $random(seed);
        case (r[2:0])
            3'd0: w[6:0] = rv_decode_pkg::opc_op;
            3'd1: w[6:0] = rv_decode_pkg::opc_op_32;
            3'd2: w[6:0] = rv_decode_pkg::opc_op_imm;
            3'd3: w[6:0] = rv_decode_pkg::opc_op_imm_32;
            3'd4: w[6:0] = rv_decode_pkg::opc_branch;
            3'd5: w[6:0] = 7'b0000011;
            3'd6: w[6:0] = 7'b1101111;
            default: begin
                // keep the random opcode
            end
        endcase
        w[11:7] = pick_reg();
        w[19:15] = pick_reg();
        w[24:20] = pick_reg();
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("MISMATCH %s at %0t: got %h expected %h", name, $time, got, want);
        error_count++;
    endtask

    // new item only when the last one was taken
    task automatic drive_inputs();
        logic [31:0] r;
        if (!stall) begin
            r = $random(seed);
            instr_valid = (r[1:0] != 2'b00);
            instr = random_word();
            pc = next_pc;
            next_pc = next_pc + 64'd4;
        end
        r = $random(seed);
        stall = (r[2:0] == 3'd0);
        flush = (r[7:4] == 4'd0);
        wb_valid = r[10];
        wb_reg = pick_reg();
        wb_data = {$random(seed), $random(seed)};
    endtask

    // expectation model, operands taken before the shadow write
    always @(posedge clk) begin
        if (reset) begin
            model_de1_valid <= 1'b0;
            model_rd1_valid <= 1'b0;
            clear_shadow();
        end else begin
            if (!stall) begin
                model_de1_valid <= instr_valid;
                model_de1_word <= instr;
                model_de1_pc <= pc;
                model_rd1_valid <= model_de1_valid && !flush;
                model_rd1_exp <= expected_outputs(model_de1_word, model_de1_pc,
                                                  wb_valid, wb_reg, wb_data);
            end else if (flush) begin
                model_de1_valid <= 1'b0;
                model_rd1_valid <= 1'b0;
            end
            if (wb_valid) begin
                write_shadow(wb_reg, wb_data);
            end
        end
    end

    always @(posedge clk) begin
        logic exp_valid;
        exp_valid = model_rd1_valid && !flush;
        if (!reset) begin
            if (out_valid !== exp_valid) begin
                report_mismatch("out_valid", out_valid, exp_valid);
            end
            if (exp_valid) begin
                if (out_uop !== model_rd1_exp.uop) begin
                    report_mismatch("out_uop", out_uop, model_rd1_exp.uop);
                end
                if (out_width_w !== model_rd1_exp.width_w) begin
                    report_mismatch("out_width_w", out_width_w, model_rd1_exp.width_w);
                end
                if (out_dst_valid !== model_rd1_exp.dst_valid) begin
                    report_mismatch("out_dst_valid", out_dst_valid, model_rd1_exp.dst_valid);
                end
                if (out_dst !== model_rd1_exp.dst) begin
                    report_mismatch("out_dst", out_dst, model_rd1_exp.dst);
                end
                if (out_src1_data !== model_rd1_exp.src1_data) begin
                    report_mismatch("out_src1_data", out_src1_data, model_rd1_exp.src1_data);
                end
                if (out_src2_data !== model_rd1_exp.src2_data) begin
                    report_mismatch("out_src2_data", out_src2_data, model_rd1_exp.src2_data);
                end
                if (out_imm !== model_rd1_exp.imm) begin
                    report_mismatch("out_imm", out_imm, model_rd1_exp.imm);
                end
                if (out_pc !== model_rd1_exp.pc) begin
                    report_mismatch("out_pc", out_pc, model_rd1_exp.pc);
                end
            end
        end
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("timeout: stimulus did not finish");
        $display("errors: %0d", error_count);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        seed = 32'h1cfc_6ff9;
        next_pc = 64'h0000_0000_8000_0000;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = 32'd0;
        pc = 64'd0;
        stall = 1'b0;
        flush = 1'b0;
        wb_valid = 1'b0;
        wb_reg = 5'd0;
        wb_data = 64'd0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_items; i++) begin
            drive_inputs();
            @(negedge clk);
        end
        // drain the pipeline
        stall = 1'b0;
        flush = 1'b0;
        instr_valid = 1'b0;
        wb_valid = 1'b0;
        repeat (4) @(negedge clk);
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+sim
hdl/rv_decode_pkg.sv
hdl/uinstr_if.sv
hdl/decode.sv
hdl/reg_read.sv
hdl/decode_top.sv
sim/tb_decode_top.sv
